// ==== decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath widths
`define XLEN        32
`define REG_IDX_W   5

// buffering and credit counts
`define IN_DEPTH    4
`define OUT_DEPTH   4
`define OUT_CREDITS 2

// alu operation codes
`define ALU_OP_W    5
`define ALUOP_NONE  5'd0
`define ALUOP_ADD   5'd1
`define ALUOP_SUB   5'd2
`define ALUOP_XOR   5'd3
`define ALUOP_OR    5'd4
`define ALUOP_AND   5'd5
`define ALUOP_SLL   5'd6
`define ALUOP_SRL   5'd7
`define ALUOP_SRA   5'd8
`define ALUOP_SLT   5'd9
`define ALUOP_SLTU  5'd10
`define ALUOP_BEQ   5'd11
`define ALUOP_BNE   5'd12
`define ALUOP_BLT   5'd13
`define ALUOP_BGE   5'd14
`define ALUOP_BLTU  5'd15
`define ALUOP_BGEU  5'd16

// memory operation codes
`define MEM_OP_W    4
`define MEMOP_NONE  4'd0
`define MEMOP_LB    4'd1
`define MEMOP_LH    4'd2
`define MEMOP_LW    4'd3
`define MEMOP_LBU   4'd4
`define MEMOP_LHU   4'd5
`define MEMOP_SB    4'd6
`define MEMOP_SH    4'd7
`define MEMOP_SW    4'd8

// execute operation codes
`define EXC_OP_W     4
`define EXCOP_NONE   4'd0
`define EXCOP_LUI    4'd1
`define EXCOP_AUIPC  4'd2
`define EXCOP_JAL    4'd3
`define EXCOP_JALR   4'd4
`define EXCOP_BRANCH 4'd5
`define EXCOP_LOAD   4'd6
`define EXCOP_STORE  4'd7
`define EXCOP_OPIMM  4'd8
`define EXCOP_OPREG  4'd9
`define EXCOP_EBREAK 4'd10

// trap bit positions
`define TRAP_W       4
`define TRAP_ILLEGAL 0
`define TRAP_ECALL   1
`define TRAP_EBREAK  2
`define TRAP_MRET    3

`endif

// ==== decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

  // plain vectors with a meaning
  typedef logic [`XLEN-1:0]      xlen_t;
  typedef logic [`XLEN-1:0]      inst_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`ALU_OP_W-1:0]  alu_op_t;
  typedef logic [`MEM_OP_W-1:0]  mem_op_t;
  typedef logic [`EXC_OP_W-1:0]  exc_op_t;
  typedef logic [`TRAP_W-1:0]    trap_vec_t;

  // what fetch hands over
  typedef struct packed {
    xlen_t pc;
    inst_t inst;
  } fetch_pkt_t;

  // what execute receives
  typedef struct packed {
    xlen_t     pc;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    reg_idx_t  rd_idx;
    xlen_t     imm;
    alu_op_t   alu_op;
    mem_op_t   mem_op;
    exc_op_t   exc_op;
    trap_vec_t trap;
    logic      ras_push;
    xlen_t     ras_ret_addr;
  } decoded_pkt_t;

  // instruction format flags, at most one set
  typedef struct packed {
    logic r;
    logic i;
    logic s;
    logic b;
    logic u;
    logic j;
  } fmt_t;

endpackage

// ==== inst_buffer.sv ====
`include "decode_config.svh"

module inst_buffer (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_valid_i,
  input  decode_pkg::fetch_pkt_t push_pkt_i,
  output logic                   pop_valid_o,
  output decode_pkg::fetch_pkt_t pop_pkt_o,
  input  logic                   pop_ready_i,
  output logic                   credit_o
);
  import decode_pkg::*;

  localparam int PTR_W = (`IN_DEPTH > 1) ? $clog2(`IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(`IN_DEPTH + 1);

  fetch_pkt_t       mem_q [`IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push_en;
  logic             pop_en;

  assign full    = (count_q == CNT_W'(`IN_DEPTH));
  assign push_en = push_valid_i && !full;
  assign pop_en  = pop_valid_o && pop_ready_i;

  // head is visible one cycle after the write
  assign pop_valid_o = (count_q != '0);
  assign pop_pkt_o   = mem_q[rd_ptr_q];

  // one credit back to fetch per freed slot
  assign credit_o = pop_en;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_pkt_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== inst_classifier.sv ====
`include "decode_config.svh"

module inst_classifier (
  input  decode_pkg::inst_t   inst_i,
  output decode_pkg::fmt_t    fmt_o,
  output decode_pkg::alu_op_t alu_op_o,
  output decode_pkg::mem_op_t mem_op_o,
  output decode_pkg::exc_op_t exc_op_o,
  output logic                is_jal_o,
  output logic                is_jalr_o,
  output logic                is_ecall_o,
  output logic                is_ebreak_o,
  output logic                is_mret_o,
  output logic                illegal_o
);
  import decode_pkg::*;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // system words match on all 32 bits
  localparam inst_t ECALL_WORD  = 32'h0000_0073;
  localparam inst_t EBREAK_WORD = 32'h0010_0073;
  localparam inst_t MRET_WORD   = 32'h3020_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_lui;
  logic       is_auipc;
  logic       is_branch;
  logic       is_load;
  logic       is_store;
  logic       is_opimm;
  logic       is_opreg;
  logic       is_system;
  logic       shamt_ok;
  logic       reg_f7_ok;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // immediate shifts keep funct7 in the upper imm bits
  always_comb begin
    case (funct3)
      3'b001:  shamt_ok = (funct7 == 7'b0000000);
      3'b101:  shamt_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      default: shamt_ok = 1'b1;
    endcase
  end

  // only add/sub and srl/sra have the alternate funct7
  assign reg_f7_ok = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

  assign is_lui    = (opcode == OPC_LUI);
  assign is_auipc  = (opcode == OPC_AUIPC);
  assign is_jal_o  = (opcode == OPC_JAL);
  assign is_jalr_o = (opcode == OPC_JALR) && (funct3 == 3'b000);
  assign is_branch = (opcode == OPC_BRANCH) && (funct3 != 3'b010) && (funct3 != 3'b011);
  assign is_load   = (opcode == OPC_LOAD) &&
                     (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  assign is_store  = (opcode == OPC_STORE) && (funct3 inside {3'b000, 3'b001, 3'b010});
  assign is_opimm  = (opcode == OPC_OPIMM) && shamt_ok;
  assign is_opreg  = (opcode == OPC_OP) && reg_f7_ok;

  assign is_ecall_o  = (inst_i == ECALL_WORD);
  assign is_ebreak_o = (inst_i == EBREAK_WORD);
  assign is_mret_o   = (inst_i == MRET_WORD);
  assign is_system   = is_ecall_o | is_ebreak_o | is_mret_o;

  assign fmt_o.r = is_opreg;
  assign fmt_o.i = is_load | is_opimm | is_jalr_o | is_system;
  assign fmt_o.s = is_store;
  assign fmt_o.b = is_branch;
  assign fmt_o.u = is_lui | is_auipc;
  assign fmt_o.j = is_jal_o;

  assign illegal_o = ~(fmt_o.r | fmt_o.i | fmt_o.s | fmt_o.b | fmt_o.u | fmt_o.j);

  always_comb begin
    alu_op_o = `ALUOP_NONE;
    if (is_lui | is_auipc | is_jal_o | is_jalr_o | is_load | is_store) begin
      alu_op_o = `ALUOP_ADD;
    end else if (is_opimm | is_opreg) begin
      case (funct3)
        // funct7 bit 5 selects sub only in the register form
        3'b000:  alu_op_o = (is_opreg && funct7[5]) ? `ALUOP_SUB : `ALUOP_ADD;
        3'b001:  alu_op_o = `ALUOP_SLL;
        3'b010:  alu_op_o = `ALUOP_SLT;
        3'b011:  alu_op_o = `ALUOP_SLTU;
        3'b100:  alu_op_o = `ALUOP_XOR;
        3'b101:  alu_op_o = funct7[5] ? `ALUOP_SRA : `ALUOP_SRL;
        3'b110:  alu_op_o = `ALUOP_OR;
        default: alu_op_o = `ALUOP_AND;
      endcase
    end else if (is_branch) begin
      case (funct3)
        3'b000:  alu_op_o = `ALUOP_BEQ;
        3'b001:  alu_op_o = `ALUOP_BNE;
        3'b100:  alu_op_o = `ALUOP_BLT;
        3'b101:  alu_op_o = `ALUOP_BGE;
        3'b110:  alu_op_o = `ALUOP_BLTU;
        default: alu_op_o = `ALUOP_BGEU;
      endcase
    end
  end

  always_comb begin
    mem_op_o = `MEMOP_NONE;
    if (is_load) begin
      case (funct3)
        3'b000:  mem_op_o = `MEMOP_LB;
        3'b001:  mem_op_o = `MEMOP_LH;
        3'b010:  mem_op_o = `MEMOP_LW;
        3'b100:  mem_op_o = `MEMOP_LBU;
        default: mem_op_o = `MEMOP_LHU;
      endcase
    end else if (is_store) begin
      case (funct3)
        3'b000:  mem_op_o = `MEMOP_SB;
        3'b001:  mem_op_o = `MEMOP_SH;
        default: mem_op_o = `MEMOP_SW;
      endcase
    end
  end

  // ecall and mret leave the execute op at none
  always_comb begin
    if (is_lui)              exc_op_o = `EXCOP_LUI;
    else if (is_auipc)       exc_op_o = `EXCOP_AUIPC;
    else if (is_jal_o)       exc_op_o = `EXCOP_JAL;
    else if (is_jalr_o)      exc_op_o = `EXCOP_JALR;
    else if (is_branch)      exc_op_o = `EXCOP_BRANCH;
    else if (is_load)        exc_op_o = `EXCOP_LOAD;
    else if (is_store)       exc_op_o = `EXCOP_STORE;
    else if (is_opimm)       exc_op_o = `EXCOP_OPIMM;
    else if (is_opreg)       exc_op_o = `EXCOP_OPREG;
    else if (is_ebreak_o)    exc_op_o = `EXCOP_EBREAK;
    else                     exc_op_o = `EXCOP_NONE;
  end

endmodule

// ==== imm_gen.sv ====
`include "decode_config.svh"

module imm_gen (
  input  decode_pkg::inst_t inst_i,
  input  decode_pkg::fmt_t  fmt_i,
  output decode_pkg::xlen_t imm_o
);
  import decode_pkg::*;

  xlen_t imm_i_type;
  xlen_t imm_s_type;
  xlen_t imm_b_type;
  xlen_t imm_u_type;
  xlen_t imm_j_type;

  assign imm_i_type = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  // branch and jump offsets are halfword aligned
  assign imm_b_type = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                       inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j_type = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                       inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};

  // r-type and illegal words carry no immediate
  always_comb begin
    if (fmt_i.i)      imm_o = imm_i_type;
    else if (fmt_i.s) imm_o = imm_s_type;
    else if (fmt_i.b) imm_o = imm_b_type;
    else if (fmt_i.u) imm_o = imm_u_type;
    else if (fmt_i.j) imm_o = imm_j_type;
    else              imm_o = '0;
  end

endmodule

// ==== decode_stage.sv ====
`include "decode_config.svh"

module decode_stage (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  input  decode_pkg::fetch_pkt_t   in_pkt_i,
  output logic                     in_ready_o,
  output logic                     out_valid_o,
  output decode_pkg::decoded_pkt_t out_pkt_o,
  input  logic                     out_ready_i
);
  import decode_pkg::*;

  fmt_t         fmt;
  alu_op_t      alu_op;
  mem_op_t      mem_op;
  exc_op_t      exc_op;
  xlen_t        imm;
  logic         is_jal;
  logic         is_jalr;
  logic         is_ecall;
  logic         is_ebreak;
  logic         is_mret;
  logic         illegal;
  reg_idx_t     rs1_field;
  reg_idx_t     rs2_field;
  reg_idx_t     rd_field;
  decoded_pkt_t dec_d;
  decoded_pkt_t pkt_q;
  logic         valid_q;
  logic         take;

  inst_classifier u_classifier (
    .inst_i      (in_pkt_i.inst),
    .fmt_o       (fmt),
    .alu_op_o    (alu_op),
    .mem_op_o    (mem_op),
    .exc_op_o    (exc_op),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr),
    .is_ecall_o  (is_ecall),
    .is_ebreak_o (is_ebreak),
    .is_mret_o   (is_mret),
    .illegal_o   (illegal)
  );

  imm_gen u_imm_gen (
    .inst_i (in_pkt_i.inst),
    .fmt_i  (fmt),
    .imm_o  (imm)
  );

  assign rs1_field = in_pkt_i.inst[19:15];
  assign rs2_field = in_pkt_i.inst[24:20];
  assign rd_field  = in_pkt_i.inst[11:7];

  always_comb begin
    dec_d              = '0;
    dec_d.pc           = in_pkt_i.pc;
    // indices the format does not use read as x0
    dec_d.rs1_idx      = (fmt.r | fmt.i | fmt.s | fmt.b) ? rs1_field : '0;
    dec_d.rs2_idx      = (fmt.r | fmt.s | fmt.b) ? rs2_field : '0;
    dec_d.rd_idx       = (fmt.r | fmt.i | fmt.u | fmt.j) ? rd_field : '0;
    dec_d.imm          = imm;
    dec_d.alu_op       = alu_op;
    dec_d.mem_op       = mem_op;
    dec_d.exc_op       = exc_op;
    dec_d.trap[`TRAP_ILLEGAL] = illegal;
    dec_d.trap[`TRAP_ECALL]   = is_ecall;
    dec_d.trap[`TRAP_EBREAK]  = is_ebreak;
    dec_d.trap[`TRAP_MRET]    = is_mret;
    // a call links through a nonzero rd
    dec_d.ras_push     = is_jal | (is_jalr & (rd_field != '0));
    dec_d.ras_ret_addr = in_pkt_i.pc + xlen_t'(4);
  end

  // refill when empty or when the held packet leaves
  assign in_ready_o = ~valid_q | out_ready_i;
  assign take       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      pkt_q <= dec_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_pkt_o   = pkt_q;

endmodule

// ==== out_queue.sv ====
`include "decode_config.svh"

module out_queue (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  input  decode_pkg::decoded_pkt_t in_pkt_i,
  output logic                     in_ready_o,
  input  logic                     credit_i,
  output logic                     dec_valid_o,
  output decode_pkg::decoded_pkt_t dec_pkt_o
);
  import decode_pkg::*;

  localparam int PTR_W  = (`OUT_DEPTH > 1) ? $clog2(`OUT_DEPTH) : 1;
  localparam int CNT_W  = $clog2(`OUT_DEPTH + 1);
  localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

  decoded_pkt_t      mem_q [`OUT_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [CRED_W-1:0] credit_q;
  logic              full;
  logic              push_en;
  logic              send;

  assign full       = (count_q == CNT_W'(`OUT_DEPTH));
  assign in_ready_o = ~full;
  assign push_en    = in_valid_i & in_ready_o;

  // a packet goes out only against a held credit
  assign send        = (count_q != '0) && (credit_q != '0);
  assign dec_valid_o = send;
  assign dec_pkt_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= in_pkt_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= CRED_W'(`OUT_CREDITS);
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`OUT_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`OUT_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // return and spend in one cycle cancel out
      case ({credit_i, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// ==== instr_decode_top.sv ====
`include "decode_config.svh"

module instr_decode_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     fetch_valid_i,
  input  decode_pkg::fetch_pkt_t   fetch_pkt_i,
  output logic                     fetch_credit_o,
  output logic                     dec_valid_o,
  output decode_pkg::decoded_pkt_t dec_pkt_o,
  input  logic                     dec_credit_i
);
  import decode_pkg::*;

  // buffer to decode
  logic         buf_valid;
  logic         buf_ready;
  fetch_pkt_t   buf_pkt;
  // decode to output queue
  logic         stg_valid;
  logic         stg_ready;
  decoded_pkt_t stg_pkt;

  inst_buffer u_inst_buffer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_valid_i (fetch_valid_i),
    .push_pkt_i   (fetch_pkt_i),
    .pop_valid_o  (buf_valid),
    .pop_pkt_o    (buf_pkt),
    .pop_ready_i  (buf_ready),
    .credit_o     (fetch_credit_o)
  );

  decode_stage u_decode_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (buf_valid),
    .in_pkt_i    (buf_pkt),
    .in_ready_o  (buf_ready),
    .out_valid_o (stg_valid),
    .out_pkt_o   (stg_pkt),
    .out_ready_i (stg_ready)
  );

  out_queue u_out_queue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (stg_valid),
    .in_pkt_i    (stg_pkt),
    .in_ready_o  (stg_ready),
    .credit_i    (dec_credit_i),
    .dec_valid_o (dec_valid_o),
    .dec_pkt_o   (dec_pkt_o)
  );

endmodule

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// alu op for the immediate and register forms, alt picks sub or sra
function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? `ALUOP_SUB : `ALUOP_ADD;
    3'd1:    return `ALUOP_SLL;
    3'd2:    return `ALUOP_SLT;
    3'd3:    return `ALUOP_SLTU;
    3'd4:    return `ALUOP_XOR;
    3'd5:    return alt ? `ALUOP_SRA : `ALUOP_SRL;
    3'd6:    return `ALUOP_OR;
    default: return `ALUOP_AND;
  endcase
endfunction

// reference decode of one fetch packet
function automatic decoded_pkt_t decode_ref(input fetch_pkt_t p);
  decoded_pkt_t d;
  inst_t        w;
  logic [2:0]   f3;
  logic [6:0]   f7;
  byte          fmt;
  w = p.inst;
  f3 = w[14:12];
  f7 = w[31:25];
  fmt = "X";
  d = '0;
  d.pc = p.pc;
  d.ras_ret_addr = p.pc + 32'd4;
  case (w[6:0])
    7'b0110111: begin
      fmt = "U";
      d.alu_op = `ALUOP_ADD;
      d.exc_op = `EXCOP_LUI;
    end
    7'b0010111: begin
      fmt = "U";
      d.alu_op = `ALUOP_ADD;
      d.exc_op = `EXCOP_AUIPC;
    end
    7'b1101111: begin
      fmt = "J";
      d.alu_op = `ALUOP_ADD;
      d.exc_op = `EXCOP_JAL;
      d.ras_push = 1'b1;
    end
    7'b1100111: begin
      if (f3 == 3'd0) begin
        fmt = "I";
        d.alu_op = `ALUOP_ADD;
        d.exc_op = `EXCOP_JALR;
        d.ras_push = (w[11:7] != 5'd0);
      end
    end
    7'b1100011: begin
      fmt = "B";
      d.exc_op = `EXCOP_BRANCH;
      case (f3)
        3'd0:    d.alu_op = `ALUOP_BEQ;
        3'd1:    d.alu_op = `ALUOP_BNE;
        3'd4:    d.alu_op = `ALUOP_BLT;
        3'd5:    d.alu_op = `ALUOP_BGE;
        3'd6:    d.alu_op = `ALUOP_BLTU;
        3'd7:    d.alu_op = `ALUOP_BGEU;
        default: fmt = "X";
      endcase
    end
    7'b0000011: begin
      fmt = "I";
      d.alu_op = `ALUOP_ADD;
      d.exc_op = `EXCOP_LOAD;
      case (f3)
        3'd0:    d.mem_op = `MEMOP_LB;
        3'd1:    d.mem_op = `MEMOP_LH;
        3'd2:    d.mem_op = `MEMOP_LW;
        3'd4:    d.mem_op = `MEMOP_LBU;
        3'd5:    d.mem_op = `MEMOP_LHU;
        default: fmt = "X";
      endcase
    end
    7'b0100011: begin
      fmt = "S";
      d.alu_op = `ALUOP_ADD;
      d.exc_op = `EXCOP_STORE;
      case (f3)
        3'd0:    d.mem_op = `MEMOP_SB;
        3'd1:    d.mem_op = `MEMOP_SH;
        3'd2:    d.mem_op = `MEMOP_SW;
        default: fmt = "X";
      endcase
    end
    7'b0010011: begin
      fmt = "I";
      d.exc_op = `EXCOP_OPIMM;
      d.alu_op = arith_op(f3, (f3 == 3'd5) && f7[5]);
      if (f3 == 3'd1 && f7 != 7'h00) fmt = "X";
      if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) fmt = "X";
    end
    7'b0110011: begin
      fmt = "R";
      d.exc_op = `EXCOP_OPREG;
      if (f7 == 7'h00) d.alu_op = arith_op(f3, 1'b0);
      else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) d.alu_op = arith_op(f3, 1'b1);
      else fmt = "X";
    end
    7'b1110011: begin
      if (w == 32'h0000_0073) begin
        fmt = "I";
        d.trap[`TRAP_ECALL] = 1'b1;
      end else if (w == 32'h0010_0073) begin
        fmt = "I";
        d.trap[`TRAP_EBREAK] = 1'b1;
        d.exc_op = `EXCOP_EBREAK;
      end else if (w == 32'h3020_0073) begin
        fmt = "I";
        d.trap[`TRAP_MRET] = 1'b1;
      end
    end
    default: fmt = "X";
  endcase
  // anything unrecognised carries only the illegal trap
  if (fmt == "X") begin
    d.alu_op = `ALUOP_NONE;
    d.mem_op = `MEMOP_NONE;
    d.exc_op = `EXCOP_NONE;
    d.ras_push = 1'b0;
    d.trap[`TRAP_ILLEGAL] = 1'b1;
  end
  if (fmt == "R" || fmt == "I" || fmt == "S" || fmt == "B") d.rs1_idx = w[19:15];
  if (fmt == "R" || fmt == "S" || fmt == "B") d.rs2_idx = w[24:20];
  if (fmt == "R" || fmt == "I" || fmt == "U" || fmt == "J") d.rd_idx = w[11:7];
  // fields are packed at the top, an arithmetic shift brings them down signed
  case (fmt)
    "I":     d.imm = $signed(w) >>> 20;
    "S":     d.imm = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
    "B":     d.imm = $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
    "U":     d.imm = {w[31:12], 12'h000};
    "J":     d.imm = $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
    default: d.imm = '0;
  endcase
  return d;
endfunction

// mostly legal rv32i words with random fields, the rest fully random
function automatic inst_t gen_inst();
  inst_t       r;
  inst_t       w;
  logic [2:0]  f3;
  logic [4:0]  rd;
  int unsigned k;
  r = $urandom();
  w = r;
  f3 = r[14:12];
  rd = r[11:7];
  k = $urandom_range(0, 9);
  if ($urandom_range(0, 9) < 8) begin
    case (k)
      0: w = {r[31:12], rd, 7'b0110111};
      1: w = {r[31:12], rd, 7'b0010111};
      2: w = {r[31:12], rd, 7'b1101111};
      3: begin
        if ($urandom_range(0, 2) == 0) rd = 5'd0;
        w = {r[31:15], 3'b000, rd, 7'b1100111};
      end
      4: begin
        k = $urandom_range(0, 5);
        f3 = (k < 2) ? 3'(k) : 3'(k + 2);
        w = {r[31:15], f3, rd, 7'b1100011};
      end
      5: begin
        k = $urandom_range(0, 4);
        f3 = (k < 3) ? 3'(k) : 3'(k + 1);
        w = {r[31:15], f3, rd, 7'b0000011};
      end
      6: w = {r[31:15], 3'($urandom_range(0, 2)), rd, 7'b0100011};
      7: begin
        if (f3 == 3'd1) r[31:25] = 7'h00;
        if (f3 == 3'd5) r[31:25] = r[30] ? 7'h20 : 7'h00;
        w = {r[31:15], f3, rd, 7'b0010011};
      end
      8: begin
        r[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
        w = {r[31:15], f3, rd, 7'b0110011};
      end
      default: begin
        k = $urandom_range(0, 2);
        w = (k == 0) ? 32'h0000_0073 : (k == 1) ? 32'h0010_0073 : 32'h3020_0073;
      end
    endcase
  end
  return w;
endfunction

`endif

// ==== tb_decode.sv ====
`include "decode_config.svh"

module tb_decode;
  import decode_pkg::*;

  `include "tb_decode_model.svh"

  localparam int SEND_LIMIT  = 5000;
  localparam int DRAIN_LIMIT = 3000;
  // system words, negative offsets, ret, calls and a few illegal words
  localparam inst_t DIRECTED [16] = '{
    32'h0000_0073, 32'h0010_0073, 32'h3020_0073, 32'hFFDF_F0EF,
    32'h0000_8067, 32'h0002_80E7, 32'hFFF3_0293, 32'hFE11_2E23,
    32'hFE00_0EE3, 32'h4020_8033, 32'h4020_D1B3, 32'h4010_D093,
    32'h4010_9093, 32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_00B7
  };

  logic         clk;
  logic         arst_n;
  logic         fetch_valid;
  fetch_pkt_t   fetch_pkt;
  logic         fetch_credit;
  logic         dec_valid;
  decoded_pkt_t dec_pkt;
  logic         dec_credit;

  fetch_pkt_t exp_q[$];
  inst_t      directed_q[$];
  string      test_name;
  int         errors;
  int         timeouts;
  int         received;
  int         fetch_credits;
  int         owed;
  int         send_budget;
  int         held_recv;
  logic       withhold;
  xlen_t      next_pc;

  instr_decode_top dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .fetch_valid_i  (fetch_valid),
    .fetch_pkt_i    (fetch_pkt),
    .fetch_credit_o (fetch_credit),
    .dec_valid_o    (dec_valid),
    .dec_pkt_o      (dec_pkt),
    .dec_credit_i   (dec_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_field(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v == act_v) else begin
      $display("Error %s %s: expected %0h actual %0h", test_name, field, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic compare_pkt(input decoded_pkt_t e, input decoded_pkt_t a);
    check_field("pc", e.pc, a.pc);
    check_field("rs1_idx", 32'(e.rs1_idx), 32'(a.rs1_idx));
    check_field("rs2_idx", 32'(e.rs2_idx), 32'(a.rs2_idx));
    check_field("rd_idx", 32'(e.rd_idx), 32'(a.rd_idx));
    check_field("imm", e.imm, a.imm);
    check_field("alu_op", 32'(e.alu_op), 32'(a.alu_op));
    check_field("mem_op", 32'(e.mem_op), 32'(a.mem_op));
    check_field("exc_op", 32'(e.exc_op), 32'(a.exc_op));
    check_field("trap", 32'(e.trap), 32'(a.trap));
    check_field("ras_push", 32'(e.ras_push), 32'(a.ras_push));
    check_field("ras_ret_addr", e.ras_ret_addr, a.ras_ret_addr);
  endtask

  // outputs are stable mid cycle
  task automatic sample_outputs();
    fetch_pkt_t sent;
    if (fetch_credit) begin
      fetch_credits++;
      assert (fetch_credits <= `IN_DEPTH) else begin
        $display("fetch credit returned while none was outstanding");
        errors++;
      end
    end
    if (dec_valid) begin
      received++;
      owed++;
      if (withhold) held_recv++;
      assert (exp_q.size() != 0) else begin
        $display("decoded packet arrived although none was outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        sent = exp_q.pop_front();
        compare_pkt(decode_ref(sent), dec_pkt);
      end
    end
  endtask

  task automatic drive_inputs();
    fetch_pkt_t pkt;
    fetch_valid = 1'b0;
    dec_credit = 1'b0;
    if (send_budget > 0 && fetch_credits > 0 && $urandom_range(0, 3) != 0) begin
      pkt.pc = next_pc;
      if (directed_q.size() != 0) pkt.inst = directed_q.pop_front();
      else pkt.inst = gen_inst();
      fetch_pkt = pkt;
      fetch_valid = 1'b1;
      exp_q.push_back(pkt);
      fetch_credits--;
      send_budget--;
      next_pc = next_pc + 32'd4;
    end
    // consumer hands credits back after a random delay
    if (!withhold && owed > 0 && $urandom_range(0, 2) == 0) begin
      dec_credit = 1'b1;
      owed--;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    #2;
    drive_inputs();
  endtask

  task automatic send_phase(input int count);
    int cycles;
    cycles = 0;
    send_budget = count;
    while (send_budget > 0 && cycles < SEND_LIMIT) begin
      run_cycle();
      cycles++;
    end
    assert (send_budget == 0) else begin
      $display("fetch stalled in %s with %0d packets unsent", test_name, send_budget);
      timeouts++;
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    send_budget = 0;
    while ((exp_q.size() != 0 || owed != 0) && cycles < DRAIN_LIMIT) begin
      run_cycle();
      cycles++;
    end
    assert (exp_q.size() == 0 && owed == 0) else begin
      $display("pipeline did not drain in %s, %0d packets never arrived",
               test_name, exp_q.size());
      timeouts++;
    end
    check_field("fetch credits after drain", `IN_DEPTH, fetch_credits);
  endtask

  initial begin
    void'($urandom(68353));
    errors = 0;
    timeouts = 0;
    received = 0;
    owed = 0;
    send_budget = 0;
    held_recv = 0;
    withhold = 1'b0;
    fetch_credits = `IN_DEPTH;
    test_name = "reset";
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_pkt = '0;
    dec_credit = 1'b0;
    repeat (16) @(posedge clk);
    check_field("fetch_credit_o", 32'd0, 32'(fetch_credit));
    check_field("dec_valid_o", 32'd0, 32'(dec_valid));
    #2;
    arst_n = 1'b1;

    test_name = "random";
    next_pc = $urandom() & 32'hFFFF_FFFC;
    send_phase(400);
    drain();

    test_name = "directed";
    foreach (DIRECTED[n]) directed_q.push_back(DIRECTED[n]);
    send_phase(directed_q.size());
    drain();

    // consumer credits held back, only the reset grant may arrive
    test_name = "backpressure";
    withhold = 1'b1;
    held_recv = 0;
    send_phase(10);
    repeat (40) run_cycle();
    assert (held_recv <= `OUT_CREDITS) else begin
      $display("Error %s: expected at most %0d packets actual %0d",
               test_name, `OUT_CREDITS, held_recv);
      errors++;
    end
    withhold = 1'b0;
    drain();

    $display("packets checked %0d, errors %0d, timeouts %0d", received, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
decode_pkg.sv
inst_buffer.sv
inst_classifier.sv
imm_gen.sv
decode_stage.sv
out_queue.sv
instr_decode_top.sv
tb_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_decode -o tb_decode_sim
./obj_dir/tb_decode_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
